// File: rtl/bmp_pkg.sv
package bmp_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // Screen coordinates.
   localparam int gpu_x_width = 10;
   localparam int gpu_y_width = 9;

   // Image width field. Wider than the screen so font sheets fit.
   localparam int bmp_width_bits = 11;

   // Bytes in one padded row of up to 3 * 2047 rounded to 4.
   localparam int row_bytes_width = bmp_width_bits + 2;

   // Display colour in 5:6:5.
   localparam int color_r_width = 5;
   localparam int color_g_width = 6;
   localparam int color_b_width = 5;

   //////////////////////////////
   // File format
   //////////////////////////////

   localparam logic [15:0] bmp_magic_bm   = 16'h4D42;
   localparam logic [15:0] bmp_ih_size_v3 = 16'd40;
   localparam logic [15:0] bmp_depth_24   = 16'd24;

   // File header plus V3 info header, in 16-bit words.
   localparam int bmp_header_words = 27;
   localparam int word_idx_width   = 5;

   // Word positions of the fields the decoder looks at.
   localparam int word_magic   = 0;
   localparam int word_ih_size = 7;
   localparam int word_width   = 9;
   localparam int word_height  = 11;
   localparam int word_depth   = 14;
   localparam int word_size_lo = 17;
   localparam int word_size_hi = 18;
   localparam int word_palette = 23;

   typedef enum logic [1:0] {
      state_idle,
      state_header,
      state_image,
      state_discard_end
   } bmp_state_t;

   // Header words that get stored.
   typedef enum logic [2:0] {
      field_width_lo,
      field_height_lo,
      field_depth,
      field_image_size_lo,
      field_image_size_hi,
      field_palette_lo,
      field_none
   } bmp_field_t;

endpackage

// File: rtl/bmp_decode_fsm.sv
module bmp_decode_fsm (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               start,
   input  logic                               pause,
   input  logic                               data_valid,
   input  logic [15:0]                        data,
   input  logic [bmp_pkg::bmp_width_bits-1:0] width,
   input  logic [bmp_pkg::gpu_y_width-1:0]    height,
   input  logic [15:0]                        depth,
   input  logic [15:0]                        palette_size,
   input  logic                               last_pixel,
   input  logic                               bytes_done,
   output logic                               ready,
   output logic                               finished,
   output logic                               accept,
   output bmp_pkg::bmp_field_t                field_sel,
   output logic                               image_begin,
   output logic                               image_phase,
   output bmp_pkg::bmp_state_t                state
);
   import bmp_pkg::*;

   logic [word_idx_width-1:0] word_idx;
   logic                      in_header;
   logic                      last_word;
   logic                      data_bad;
   logic                      stored_bad;

   //////////////////////////////
   // Handshake
   //////////////////////////////

   // Trailing bytes are drained even while paused.
   assign ready = (state != state_idle) &&
                  (!pause || state == state_discard_end);

   // A word arriving with start is dropped.
   assign accept = ready && data_valid && !start;

   assign finished    = (state == state_idle);
   assign image_phase = (state == state_image);
   assign in_header   = (state == state_header);
   assign last_word   = (word_idx == word_idx_width'(bmp_header_words - 1));

   //////////////////////////////
   // Header checks
   //////////////////////////////

   // Fields that are only checked, never stored.
   always_comb begin
      data_bad = 1'b0;
      case (word_idx)
         word_magic:   data_bad = (data != bmp_magic_bm);
         word_ih_size: data_bad = (data != bmp_ih_size_v3);
         default:      data_bad = 1'b0;
      endcase
   end

   // Stored fields are checked once their word has gone by.
   // A zero sized image is refused as well.
   assign stored_bad = (word_idx > word_depth && depth != bmp_depth_24) ||
                       (word_idx > word_palette && palette_size != 16'd0) ||
                       (word_idx > word_height && (width == '0 || height == '0));

   assign image_begin = in_header && accept && last_word && !data_bad && !stored_bad;

   // Field capture strobes.
   always_comb begin
      field_sel = field_none;
      if (in_header) begin
         case (word_idx)
            word_width:   field_sel = field_width_lo;
            word_height:  field_sel = field_height_lo;
            word_depth:   field_sel = field_depth;
            word_size_lo: field_sel = field_image_size_lo;
            word_size_hi: field_sel = field_image_size_hi;
            word_palette: field_sel = field_palette_lo;
            default:      field_sel = field_none;
         endcase
      end
   end

   //////////////////////////////
   // State register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= state_idle;
         word_idx <= '0;
      end else if (start) begin
         state    <= state_header;
         word_idx <= '0;
      end else begin
         case (state)
            state_header: begin
               if (stored_bad) begin
                  state <= state_idle;
               end else if (accept) begin
                  word_idx <= word_idx + 1'b1;
                  if (data_bad) begin
                     state <= state_idle;
                  end else if (last_word) begin
                     state <= state_image;
                  end
               end
            end
            state_image: begin
               // Running out of bytes wins over the last pixel.
               if (accept) begin
                  if (bytes_done) begin
                     state <= state_idle;
                  end else if (last_pixel) begin
                     state <= state_discard_end;
                  end
               end
            end
            state_discard_end: begin
               if (accept && bytes_done) begin
                  state <= state_idle;
               end
            end
            default: begin
               state <= state_idle;
            end
         endcase
      end
   end

endmodule

// File: rtl/bmp_header_fields.sv
module bmp_header_fields (
   input  logic                               clk,
   input  logic [15:0]                        data,
   input  logic                               accept,
   input  bmp_pkg::bmp_field_t                field_sel,
   output logic [bmp_pkg::bmp_width_bits-1:0] width,
   output logic [bmp_pkg::gpu_y_width-1:0]    height,
   output logic [15:0]                        depth,
   output logic [15:0]                        palette_size,
   output logic [31:0]                        image_size
);
   import bmp_pkg::*;

   //////////////////////////////
   // Field registers
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (accept) begin
         case (field_sel)
            field_width_lo: begin
               // May be wider than the screen.
               width <= data[bmp_width_bits-1:0];
            end
            field_height_lo: begin
               // Limited to the screen height.
               height <= data[gpu_y_width-1:0];
            end
            field_depth: begin
               depth <= data;
            end
            field_image_size_lo: begin
               image_size[15:0] <= data;
            end
            field_image_size_hi: begin
               image_size[31:16] <= data;
            end
            field_palette_lo: begin
               // Upper half of the count is ignored.
               palette_size <= data;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: rtl/bmp_raster_counter.sv
module bmp_raster_counter (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               accept,
   input  logic                               image_begin,
   input  logic                               image_phase,
   input  logic                               pixel_done,
   input  logic [bmp_pkg::bmp_width_bits-1:0] width,
   input  logic [bmp_pkg::gpu_y_width-1:0]    height,
   input  logic [31:0]                        image_size,
   output logic [bmp_pkg::gpu_x_width-1:0]    pos_x,
   output logic [bmp_pkg::gpu_y_width-1:0]    pos_y,
   output logic                               row_pad_lo,
   output logic                               row_pad_hi,
   output logic                               last_pixel,
   output logic                               bytes_done
);
   import bmp_pkg::*;

   logic [row_bytes_width-1:0] pix_bytes;
   logic [row_bytes_width-1:0] pix_round;
   logic [row_bytes_width-1:0] row_len;
   logic [row_bytes_width-1:0] byte_pos;
   logic [row_bytes_width-1:0] byte_pos_hi;
   logic [row_bytes_width-1:0] byte_pos_next;
   logic [bmp_width_bits-1:0]  column;
   logic [gpu_y_width-1:0]     row;
   logic [31:0]                remaining;
   logic                       last_column;
   logic                       row_wrap;

   // Three bytes per pixel and rows padded to 4 bytes.
   assign pix_bytes = {2'b00, width} + {1'b0, width, 1'b0};
   assign pix_round = pix_bytes + row_bytes_width'(3);
   assign row_len   = {pix_round[row_bytes_width-1:2], 2'b00};

   // Rows are a multiple of 4, so a word never straddles two rows.
   assign byte_pos_hi   = byte_pos + 1'b1;
   assign byte_pos_next = byte_pos + row_bytes_width'(2);
   assign row_wrap      = (byte_pos_next == row_len);
   assign row_pad_lo    = (byte_pos >= pix_bytes);
   assign row_pad_hi    = (byte_pos_hi >= pix_bytes);

   assign last_column = (column == width - 1'b1);
   assign last_pixel  = pixel_done && last_column && (row == '0);
   assign bytes_done  = (remaining <= 32'd2);

   always_ff @(posedge clk) begin
      if (reset) begin
         byte_pos  <= '0;
         column    <= '0;
         row       <= '0;
         remaining <= '0;
      end else if (image_begin) begin
         // Bottom row first.
         byte_pos  <= '0;
         column    <= '0;
         row       <= height - 1'b1;
         remaining <= image_size;
      end else begin
         if (accept) begin
            remaining <= bytes_done ? 32'd0 : remaining - 32'd2;
         end
         if (accept && image_phase) begin
            if (row_wrap) begin
               byte_pos <= '0;
               row      <= row - 1'b1;
            end else begin
               byte_pos <= byte_pos_next;
            end
         end
         if (pixel_done) begin
            column <= last_column ? '0 : column + 1'b1;
         end
      end
   end

   // Coordinates land on the same edge as the pixel.
   always_ff @(posedge clk) begin
      if (pixel_done) begin
         pos_x <= column[gpu_x_width-1:0];
         pos_y <= row;
      end
   end

endmodule

// File: rtl/bgr_unpacker.sv
module bgr_unpacker (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              start,
   input  logic                              accept,
   input  logic                              image_begin,
   input  logic                              image_phase,
   input  logic                              row_pad_lo,
   input  logic                              row_pad_hi,
   input  logic [15:0]                       data,
   output logic                              pixel_valid,
   output logic [bmp_pkg::color_r_width-1:0] pixel_r,
   output logic [bmp_pkg::color_g_width-1:0] pixel_g,
   output logic [bmp_pkg::color_b_width-1:0] pixel_b,
   output logic                              pixel_done
);
   import bmp_pkg::*;

   typedef enum logic [1:0] {
      phase_blue,
      phase_green,
      phase_red
   } byte_phase_t;

   byte_phase_t              phase;
   byte_phase_t              phase_n;
   logic [color_b_width-1:0] blue_q;
   logic [color_b_width-1:0] blue_n;
   logic [color_b_width-1:0] out_b;
   logic [color_g_width-1:0] green_q;
   logic [color_g_width-1:0] green_n;
   logic [color_g_width-1:0] out_g;
   logic [color_r_width-1:0] out_r;
   logic [7:0]               cur_byte;
   logic                     cur_pad;

   //////////////////////////////
   // Byte walk from the low byte
   //////////////////////////////

   always_comb begin
      phase_n    = phase;
      blue_n     = blue_q;
      green_n    = green_q;
      out_b      = blue_q;
      out_g      = green_q;
      out_r      = '0;
      pixel_done = 1'b0;
      cur_byte   = data[7:0];
      cur_pad    = row_pad_lo;
      if (accept && image_phase) begin
         for (int i = 0; i < 2; i++) begin
            cur_byte = (i == 0) ? data[7:0] : data[15:8];
            cur_pad  = (i == 0) ? row_pad_lo : row_pad_hi;
            if (!cur_pad) begin
               case (phase_n)
                  phase_blue: begin
                     blue_n  = cur_byte[7 -: color_b_width];
                     phase_n = phase_green;
                  end
                  phase_green: begin
                     green_n = cur_byte[7 -: color_g_width];
                     phase_n = phase_red;
                  end
                  default: begin
                     // Take blue and green before a following blue replaces them.
                     out_b      = blue_n;
                     out_g      = green_n;
                     out_r      = cur_byte[7 -: color_r_width];
                     pixel_done = 1'b1;
                     phase_n    = phase_blue;
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase       <= phase_blue;
         pixel_valid <= 1'b0;
      end else if (start) begin
         phase       <= phase_blue;
         pixel_valid <= 1'b0;
      end else begin
         phase       <= image_begin ? phase_blue : phase_n;
         pixel_valid <= pixel_done;
      end
   end

   // Partial pixel and output colour.
   always_ff @(posedge clk) begin
      blue_q  <= blue_n;
      green_q <= green_n;
      if (pixel_done) begin
         pixel_r <= out_r;
         pixel_g <= out_g;
         pixel_b <= out_b;
      end
   end

endmodule

// File: rtl/image_decode_bmp.sv
module image_decode_bmp (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              pause,
   input  logic                              start,
   output logic                              finished,
   input  logic                              data_valid,
   output logic                              ready,
   input  logic [15:0]                       data,
   output logic                              pixel_valid,
   output logic [bmp_pkg::gpu_x_width-1:0]   pos_x,
   output logic [bmp_pkg::gpu_y_width-1:0]   pos_y,
   output logic [bmp_pkg::color_r_width-1:0] pixel_r,
   output logic [bmp_pkg::color_g_width-1:0] pixel_g,
   output logic [bmp_pkg::color_b_width-1:0] pixel_b
);
   import bmp_pkg::*;

   logic                      accept;
   logic                      image_begin;
   logic                      image_phase;
   bmp_field_t                field_sel;
   bmp_state_t                state;
   logic [bmp_width_bits-1:0] width;
   logic [gpu_y_width-1:0]    height;
   logic [15:0]               depth;
   logic [15:0]               palette_size;
   logic [31:0]               image_size;
   logic                      row_pad_lo;
   logic                      row_pad_hi;
   logic                      last_pixel;
   logic                      bytes_done;
   logic                      pixel_done;

   //////////////////////////////
   // Control
   //////////////////////////////

   bmp_decode_fsm i_bmp_decode_fsm (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .pause        (pause),
      .data_valid   (data_valid),
      .data         (data),
      .width        (width),
      .height       (height),
      .depth        (depth),
      .palette_size (palette_size),
      .last_pixel   (last_pixel),
      .bytes_done   (bytes_done),
      .ready        (ready),
      .finished     (finished),
      .accept       (accept),
      .field_sel    (field_sel),
      .image_begin  (image_begin),
      .image_phase  (image_phase),
      .state        (state)
   );

   bmp_header_fields i_bmp_header_fields (
      .clk          (clk),
      .data         (data),
      .accept       (accept),
      .field_sel    (field_sel),
      .width        (width),
      .height       (height),
      .depth        (depth),
      .palette_size (palette_size),
      .image_size   (image_size)
   );

   //////////////////////////////
   // Pixel path
   //////////////////////////////

   bmp_raster_counter i_bmp_raster_counter (
      .clk         (clk),
      .reset       (reset),
      .accept      (accept),
      .image_begin (image_begin),
      .image_phase (image_phase),
      .pixel_done  (pixel_done),
      .width       (width),
      .height      (height),
      .image_size  (image_size),
      .pos_x       (pos_x),
      .pos_y       (pos_y),
      .row_pad_lo  (row_pad_lo),
      .row_pad_hi  (row_pad_hi),
      .last_pixel  (last_pixel),
      .bytes_done  (bytes_done)
   );

   bgr_unpacker i_bgr_unpacker (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .accept      (accept),
      .image_begin (image_begin),
      .image_phase (image_phase),
      .row_pad_lo  (row_pad_lo),
      .row_pad_hi  (row_pad_hi),
      .data        (data),
      .pixel_valid (pixel_valid),
      .pixel_r     (pixel_r),
      .pixel_g     (pixel_g),
      .pixel_b     (pixel_b),
      .pixel_done  (pixel_done)
   );

endmodule

// File: test/image_decode_bmp_properties.sv
module image_decode_bmp_properties (
   input logic                clk,
   input logic                reset,
   input logic                pause,
   input logic                ready,
   input logic                finished,
   input logic                pixel_valid,
   input bmp_pkg::bmp_state_t state
);
   timeunit 1ns;
   timeprecision 100ps;
   import bmp_pkg::*;

   // Number of failed assertions.
   int fail_count = 0;

   //////////////////////////////
   // Handshake
   //////////////////////////////

   // An idle decoder takes no words.
   idle_not_ready: assert property (@(posedge clk) disable iff (reset)
      finished |-> !ready)
      else begin
         fail_count++;
         $error("ready is high while finished is high");
      end

   // Pause holds off every word except the trailing ones.
   pause_blocks_ready: assert property (@(posedge clk) disable iff (reset)
      (pause && state != state_discard_end) |-> !ready)
      else begin
         fail_count++;
         $error("ready is high during pause outside discard_end");
      end

   //////////////////////////////
   // Pixel output
   //////////////////////////////

   // No pixel before the image data.
   no_pixel_outside_image: assert property (@(posedge clk) disable iff (reset)
      (state == state_idle || state == state_header) |-> !pixel_valid)
      else begin
         fail_count++;
         $error("pixel_valid is high in idle or header");
      end

endmodule

// File: test/tb_image_decode_bmp.sv
module tb_image_decode_bmp;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [15:0] magic_bm = 16'h4D42;

   logic        clk;
   logic        reset;
   logic        pause;
   logic        start;
   logic        finished;
   logic        data_valid;
   logic        ready;
   logic [15:0] data;
   logic        pixel_valid;
   logic [9:0]  pos_x;
   logic [8:0]  pos_y;
   logic [4:0]  pixel_r;
   logic [5:0]  pixel_g;
   logic [4:0]  pixel_b;

   // Expected pixel is {x, y, r, g, b}.
   logic [15:0] words[$];
   logic [34:0] expected[$];
   int          exp_word[$];
   int          disc_from;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   int          limit = 2000;
   string       test_name = "reset";

   image_decode_bmp i_image_decode_bmp (
      .clk         (clk),
      .reset       (reset),
      .pause       (pause),
      .start       (start),
      .finished    (finished),
      .data_valid  (data_valid),
      .ready       (ready),
      .data        (data),
      .pixel_valid (pixel_valid),
      .pos_x       (pos_x),
      .pos_y       (pos_y),
      .pixel_r     (pixel_r),
      .pixel_g     (pixel_g),
      .pixel_b     (pixel_b)
   );

   bind image_decode_bmp image_decode_bmp_properties i_image_decode_bmp_properties (
      .clk         (clk),
      .reset       (reset),
      .pause       (pause),
      .ready       (ready),
      .finished    (finished),
      .pixel_valid (pixel_valid),
      .state       (state)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Stream building
   //////////////////////////////

   function automatic int image_words(input int w, input int h, input int extra);
      return 27 + ((3 * w + 3) / 4 * 4 * h) / 2 + extra;
   endfunction

   task automatic build_image(input int w, input int h, input logic [15:0] magic,
                              input logic [15:0] ih_size, input logic [15:0] depth,
                              input logic [15:0] palette, input int extra);
      logic [7:0]  bytes[$];
      logic [23:0] bgr;
      int          size;
      bit          good;
      size = (3 * w + 3) / 4 * 4 * h + 2 * extra;
      good = (magic == magic_bm) && (ih_size == 16'd40) && (depth == 16'd24) &&
             (palette == 16'd0);
      words.delete();
      expected.delete();
      exp_word.delete();
      for (int i = 0; i < 27; i++) begin
         words.push_back(16'h0000);
      end
      words[0]  = magic;
      words[1]  = 16'(54 + size);
      words[5]  = 16'd54;
      words[7]  = ih_size;
      words[9]  = 16'(w);
      words[11] = 16'(h);
      words[13] = 16'd1;
      words[14] = depth;
      words[17] = 16'(size);
      words[18] = 16'(size >> 16);
      words[23] = palette;
      // First row in the file is the bottom of the screen.
      for (int r = 0; r < h; r++) begin
         for (int x = 0; x < w; x++) begin
            bgr = 24'($urandom);
            bytes.push_back(bgr[7:0]);
            bytes.push_back(bgr[15:8]);
            bytes.push_back(bgr[23:16]);
            if (good) begin
               expected.push_back({10'(x), 9'(h - 1 - r), bgr[23:19], bgr[15:10], bgr[7:3]});
               exp_word.push_back(27 + (bytes.size() - 1) / 2);
            end
         end
         while (bytes.size() % 4 != 0) begin
            bytes.push_back(8'h00);
         end
      end
      for (int i = 0; i < 2 * extra; i++) begin
         bytes.push_back(8'($urandom));
      end
      for (int i = 0; i < bytes.size(); i += 2) begin
         words.push_back({bytes[i + 1], bytes[i]});
      end
      disc_from = good ? exp_word[$] + 1 : words.size();
   endtask

   //////////////////////////////
   // Driving and checks
   //////////////////////////////

   task automatic expect_bit(input string what, input logic want, input logic got);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("[ERROR] %s: %s expected %0b, got %0b", test_name, what, want, got);
      end
   endtask

   task automatic expect_empty();
      checks++;
      assert (expected.size() == 0) else begin
         errors++;
         $display("[ERROR] %s: pixels left expected 0, got %0d", test_name, expected.size());
      end
   endtask

   task automatic pulse_start();
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
   endtask

   // Called 1 ns after a rising edge and returns at the same point.
   task automatic drive_words(input int count, input bit gaps);
      int idx;
      bit stop;
      idx = 0;
      stop = 1'b0;
      while (idx < count && !stop) begin
         data       = words[idx];
         data_valid = gaps ? (($urandom % 4) != 0) : 1'b1;
         pause      = gaps ? (($urandom % 5) == 0) : 1'b0;
         @(negedge clk);
         if (idx >= disc_from) begin
            expect_bit("ready in discard_end", 1'b1, ready);
         end
         if (ready && data_valid) begin
            idx++;
         end else if (finished) begin
            stop = 1'b1;
         end
         @(posedge clk);
         #1;
      end
      data_valid = 1'b0;
      pause      = 1'b0;
   endtask

   task automatic decode_image(input string name, input int w, input int h, input bit gaps);
      test_name = $sformatf("%s_w%0d_h%0d", name, w, h);
      build_image(w, h, magic_bm, 16'd40, 16'd24, 16'd0, 3);
      pulse_start();
      drive_words(words.size(), gaps);
      while (!finished) begin
         @(negedge clk);
      end
      expect_empty();
   endtask

   task automatic reject_image(input string name, input logic [15:0] magic,
                               input logic [15:0] ih_size, input logic [15:0] depth,
                               input logic [15:0] palette);
      test_name = name;
      build_image(4, 2, magic, ih_size, depth, palette, 2);
      pulse_start();
      drive_words(words.size(), 1'b1);
      repeat (4) @(negedge clk);
      expect_bit("finished", 1'b1, finished);
   endtask

   // Every pixel must match the head of the expected queue.
   always @(negedge clk) begin : pixel_monitor
      logic [34:0] got;
      got = {pos_x, pos_y, pixel_r, pixel_g, pixel_b};
      if (!reset && pixel_valid) begin
         checks++;
         assert (expected.size() > 0) else begin
            errors++;
            $display("Test %s produced a pixel at x %0d y %0d where none was due",
                     test_name, pos_x, pos_y);
         end
         if (expected.size() > 0) begin
            assert (got == expected[0]) else begin
               errors++;
               $display("[ERROR] %s: pixel expected %h, got %h", test_name, expected[0], got);
            end
            void'(expected.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("Timeout: the run did not end within %0d cycles", limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      int total;
      void'($urandom(94));
      reset      = 1'b1;
      pause      = 1'b0;
      start      = 1'b0;
      data_valid = 1'b0;
      data       = 16'h0000;
      disc_from  = 0;
      total = 4 * image_words(4, 2, 2) + image_words(6, 3, 2) + image_words(5, 2, 3);
      for (int w = 4; w < 8; w++) begin
         for (int h = 1; h < 4; h++) begin
            total += 2 * image_words(w, h, 3);
         end
      end
      limit = 4 * total + 2000;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      expect_bit("finished", 1'b1, finished);
      expect_bit("ready", 1'b0, ready);
      expect_bit("pixel_valid", 1'b0, pixel_valid);

      // All four padding cases and then the same with stalls.
      for (int w = 4; w < 8; w++) begin
         for (int h = 1; h < 4; h++) begin
            decode_image("plain", w, h, 1'b0);
         end
      end
      for (int w = 4; w < 8; w++) begin
         for (int h = 1; h < 4; h++) begin
            decode_image("stalled", w, h, 1'b1);
         end
      end

      reject_image("bad_magic", 16'h4D43, 16'd40, 16'd24, 16'd0);
      reject_image("bad_ih_size", magic_bm, 16'd12, 16'd24, 16'd0);
      reject_image("bad_depth", magic_bm, 16'd40, 16'd8, 16'd0);
      reject_image("bad_palette", magic_bm, 16'd40, 16'd24, 16'd16);

      // Cut an image off in its second row and then send a clean one.
      test_name = "abort";
      build_image(6, 3, magic_bm, 16'd40, 16'd24, 16'd0, 2);
      while (exp_word.size() > 0 && exp_word[$] >= 39) begin
         void'(exp_word.pop_back());
         void'(expected.pop_back());
      end
      pulse_start();
      drive_words(39, 1'b1);
      repeat (2) @(negedge clk);
      expect_empty();
      decode_image("after_abort", 5, 2, 1'b1);

      errors += i_image_decode_bmp.i_image_decode_bmp_properties.fail_count;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
rtl/bmp_pkg.sv
rtl/bmp_decode_fsm.sv
rtl/bmp_header_fields.sv
rtl/bmp_raster_counter.sv
rtl/bgr_unpacker.sv
rtl/image_decode_bmp.sv
test/image_decode_bmp_properties.sv
test/tb_image_decode_bmp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the BMP decoder testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_image_decode_bmp \
   -f vlog.f \
   -o sim_tb

# Keep running past assertion errors so the testbench prints its verdict.
obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi

if ! grep -q "TEST OK" sim.log; then
   echo "Simulation ended without a verdict, see sim.log"
   exit 1
fi

echo "Simulation passed"
